// File: Makefile
TOP := tb_ext_periph_subsys

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f ext_periph_subsys.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

// File: ext_periph_macros.svh
/* Widths, sizes, latency and address map of the external-peripheral subsystem.
   Include wherever one of these values is needed. */

`ifndef EXT_PERIPH_MACROS_SVH
`define EXT_PERIPH_MACROS_SVH

// Register bus
`define DATA_WIDTH 32
`define ADDR_WIDTH 32

// Power switching
`define EXT_DOMAINS 2
`define NUM_BANKS 4
`define SWITCH_ACK_LATENCY 15

// Interfaced FIFO
`define IFFIFO_DEPTH 8

// Peripheral windows
`define IFFIFO_BASE 32'h0000_0000
`define PWR_BASE 32'h0000_1000
`define PERIPH_SIZE 32'h1000

`endif

// File: ext_periph_subsys.f
+incdir+.
reg_bus_pkg.sv
power_pkg.sv
reg_demux.sv
iffifo_periph.sv
power_ctrl_regs.sv
switch_ack_delay.sv
ext_periph_subsys.sv
tb_clk_gen.sv
tb_ext_periph_subsys.sv

// File: ext_periph_subsys.sv
/* Top level of the external-peripheral subsystem. Joins the register demux,
   the FIFO and power peripherals, the switch-cell models and the IRQ vector. */

`timescale 1ns/1ps

`include "ext_periph_macros.svh"

module ext_periph_subsys import reg_bus_pkg::*, power_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  reg_req_t     reg_req_i,
  output reg_rsp_t     reg_rsp_o,
  output domain_mask_t powergate_switch_n_o,
  output bank_mask_t   bank_switch_n_o,
  output logic         dma_slot_tx_o,
  output logic         dma_slot_rx_o,
  output intr_vec_t    intr_vector_o
);

  reg_req_t     fifo_req, pwr_req;
  reg_rsp_t     fifo_rsp, pwr_rsp;
  domain_mask_t domain_ack_n;
  bank_mask_t   bank_ack_n;
  logic         iffifo_irq, pwr_irq;

  reg_demux reg_demux_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .host_req_i (reg_req_i),
    .host_rsp_o (reg_rsp_o),
    .fifo_req_o (fifo_req),
    .fifo_rsp_i (fifo_rsp),
    .pwr_req_o  (pwr_req),
    .pwr_rsp_i  (pwr_rsp)
  );

  iffifo_periph iffifo_periph_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (fifo_req),
    .rsp_o       (fifo_rsp),
    .in_ready_o  (dma_slot_tx_o),
    .out_valid_o (dma_slot_rx_o),
    .irq_o       (iffifo_irq)
  );

  power_ctrl_regs power_ctrl_regs_i (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .req_i             (pwr_req),
    .rsp_o             (pwr_rsp),
    .domain_switch_n_o (powergate_switch_n_o),
    .bank_switch_n_o   (bank_switch_n_o),
    .domain_ack_n_i    (domain_ack_n),
    .bank_ack_n_i      (bank_ack_n),
    .irq_o             (pwr_irq)
  );

  // Switch cells for the external domains and the memory banks
  switch_ack_delay #(
    .ack_t   (domain_mask_t),
    .LATENCY (`SWITCH_ACK_LATENCY)
  ) domain_ack_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .switch_n_i (powergate_switch_n_o),
    .ack_n_o    (domain_ack_n)
  );

  switch_ack_delay #(
    .ack_t   (bank_mask_t),
    .LATENCY (`SWITCH_ACK_LATENCY)
  ) bank_ack_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .switch_n_i (bank_switch_n_o),
    .ack_n_o    (bank_ack_n)
  );

  assign intr_vector_o.iffifo_irq = iffifo_irq;
  assign intr_vector_o.pwr_irq    = pwr_irq;

endmodule

// File: iffifo_periph.sv
/* Register-mapped FIFO: DATA pushes on write and pops on read, STATUS holds the
   fill count and WATERMARK sets the interrupt level. Drives two DMA slot lines. */

`timescale 1ns/1ps

`include "ext_periph_macros.svh"

module iffifo_periph import reg_bus_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  reg_req_t req_i,
  output reg_rsp_t rsp_o,
  output logic     in_ready_o,
  output logic     out_valid_o,
  output logic     irq_o
);

  localparam int PTR_W = $clog2(`IFFIFO_DEPTH);
  localparam int CNT_W = $clog2(`IFFIFO_DEPTH + 1);

  localparam logic [`ADDR_WIDTH-1:0] OFS_DATA   = 'h0;
  localparam logic [`ADDR_WIDTH-1:0] OFS_STATUS = 'h4;
  localparam logic [`ADDR_WIDTH-1:0] OFS_WM     = 'h8;

  logic [`DATA_WIDTH-1:0] mem [`IFFIFO_DEPTH];
  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       rd_ptr;
  logic [CNT_W-1:0]       count;
  logic [`DATA_WIDTH-1:0] watermark;
  logic [`DATA_WIDTH-1:0] count_ext;

  logic [`ADDR_WIDTH-1:0] offset;
  logic is_data, is_status, is_wm;
  logic full, empty;
  logic push, pop;

  assign offset    = req_i.addr & `ADDR_WIDTH'(`PERIPH_SIZE - 1);
  assign is_data   = (offset == OFS_DATA);
  assign is_status = (offset == OFS_STATUS);
  assign is_wm     = (offset == OFS_WM);

  assign full      = (count == CNT_W'(`IFFIFO_DEPTH));
  assign empty     = (count == '0);
  assign count_ext = `DATA_WIDTH'(count);

  assign push = req_i.valid && req_i.write && is_data && !full;
  assign pop  = req_i.valid && !req_i.write && is_data && !empty;

  always_comb begin
    rsp_o.ready = req_i.valid;
    rsp_o.error = req_i.valid && ((is_data && req_i.write && full) ||
                                  (is_data && !req_i.write && empty) ||
                                  (is_status && req_i.write) ||
                                  !(is_data || is_status || is_wm));
    rsp_o.rdata = '0;
    if (req_i.valid && !req_i.write) begin
      if (pop) begin
        rsp_o.rdata = mem[rd_ptr];
      end else if (is_status) begin
        rsp_o.rdata = count_ext;
      end else if (is_wm) begin
        rsp_o.rdata = watermark;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr] <= req_i.wdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      watermark <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(`IFFIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        count  <= count + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(`IFFIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        count  <= count - 1'b1;
      end
      if (req_i.valid && req_i.write && is_wm) begin
        watermark <= req_i.wdata;
      end
    end
  end

  // DMA slots
  assign in_ready_o  = !full;
  assign out_valid_o = !empty;

  assign irq_o = (watermark != '0) && (count_ext >= watermark);

  a_count_bound: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    count <= CNT_W'(`IFFIFO_DEPTH)
  );

  // A push into a full FIFO is dropped
  a_full_drop: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    full && req_i.valid && req_i.write && is_data |=> $stable(wr_ptr) && full
  );

endmodule

// File: power_ctrl_regs.sv
/* Power-switch request registers for external domains and memory banks.
   Reports the returned acks and raises an interrupt once a change has settled. */

`timescale 1ns/1ps

`include "ext_periph_macros.svh"

module power_ctrl_regs import reg_bus_pkg::*, power_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  reg_req_t     req_i,
  output reg_rsp_t     rsp_o,
  output domain_mask_t domain_switch_n_o,
  output bank_mask_t   bank_switch_n_o,
  input  domain_mask_t domain_ack_n_i,
  input  bank_mask_t   bank_ack_n_i,
  output logic         irq_o
);

  localparam logic [`ADDR_WIDTH-1:0] OFS_DOMAIN = 'h0;
  localparam logic [`ADDR_WIDTH-1:0] OFS_BANK   = 'h4;
  localparam logic [`ADDR_WIDTH-1:0] OFS_ACK    = 'h8;
  localparam logic [`ADDR_WIDTH-1:0] OFS_IRQ    = 'hc;

  logic [`ADDR_WIDTH-1:0] offset;
  logic [`DATA_WIDTH-1:0] ack_status;
  logic wr_en, wr_switch, settled;
  logic change_pending;
  logic irq_q;

  assign offset = req_i.addr & `ADDR_WIDTH'(`PERIPH_SIZE - 1);
  assign wr_en  = req_i.valid && req_i.write;

  assign wr_switch = wr_en && ((offset == OFS_DOMAIN) || (offset == OFS_BANK));
  assign settled   = change_pending && (domain_ack_n_i == domain_switch_n_o) &&
                     (bank_ack_n_i == bank_switch_n_o);

  // Bank acks start at bit 8
  always_comb begin
    ack_status = '0;
    ack_status[0 +: `EXT_DOMAINS] = domain_ack_n_i;
    ack_status[8 +: `NUM_BANKS]   = bank_ack_n_i;
  end

  always_comb begin
    rsp_o.ready = req_i.valid;
    rsp_o.error = 1'b0;
    rsp_o.rdata = '0;
    case (offset)
      OFS_DOMAIN: rsp_o.rdata = `DATA_WIDTH'(domain_switch_n_o);
      OFS_BANK:   rsp_o.rdata = `DATA_WIDTH'(bank_switch_n_o);
      OFS_ACK: begin
        rsp_o.rdata = ack_status;
        rsp_o.error = wr_en;
      end
      OFS_IRQ:    rsp_o.rdata = `DATA_WIDTH'(irq_q);
      default:    rsp_o.error = req_i.valid;
    endcase
    if (req_i.write) begin
      rsp_o.rdata = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      domain_switch_n_o <= '0;
      bank_switch_n_o   <= '0;
      change_pending    <= 1'b0;
      irq_q             <= 1'b0;
    end else begin
      if (wr_en && offset == OFS_DOMAIN) begin
        domain_switch_n_o <= req_i.wdata[`EXT_DOMAINS-1:0];
      end
      if (wr_en && offset == OFS_BANK) begin
        bank_switch_n_o <= req_i.wdata[`NUM_BANKS-1:0];
      end
      if (wr_en && offset == OFS_IRQ && req_i.wdata[0]) begin
        irq_q <= 1'b0;
      end
      if (settled) begin
        change_pending <= 1'b0;
        irq_q          <= 1'b1;
      end
      // A new request restarts the wait
      if (wr_switch) begin
        change_pending <= 1'b1;
      end
    end
  end

  assign irq_o = irq_q;

  a_irq_settled: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $rose(irq_o) |-> $past((domain_ack_n_i == domain_switch_n_o) &&
                           (bank_ack_n_i == bank_switch_n_o))
  );

endmodule

// File: power_pkg.sv
/* Power-switch mask types for external domains and memory banks, and the
   external interrupt vector. */

`include "ext_periph_macros.svh"

package power_pkg;

  // One active-low bit per external domain
  typedef logic [`EXT_DOMAINS-1:0] domain_mask_t;

  // One active-low bit per memory bank
  typedef logic [`NUM_BANKS-1:0] bank_mask_t;

  typedef struct packed {
    logic iffifo_irq;
    logic pwr_irq;
  } intr_vec_t;

endpackage

// File: reg_bus_pkg.sv
/* Register-bus request and response types and the peripheral select code
   used by the address decoder. */

`include "ext_periph_macros.svh"

package reg_bus_pkg;

  typedef struct packed {
    logic                   valid;
    logic                   write;
    logic [`ADDR_WIDTH-1:0] addr;
    logic [`DATA_WIDTH-1:0] wdata;
  } reg_req_t;

  // ready comes back in the same cycle as valid
  typedef struct packed {
    logic                   ready;
    logic                   error;
    logic [`DATA_WIDTH-1:0] rdata;
  } reg_rsp_t;

  typedef enum logic [1:0] {
    SEL_IFFIFO = 2'd0,
    SEL_PWR    = 2'd1,
    SEL_NONE   = 2'd2
  } periph_sel_t;

endpackage

// File: reg_demux.sv
/* Decodes the host register address and routes each access to the FIFO or the
   power-control peripheral. Unmapped accesses are answered here with an error. */

`timescale 1ns/1ps

`include "ext_periph_macros.svh"

module reg_demux import reg_bus_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  reg_req_t host_req_i,
  output reg_rsp_t host_rsp_o,
  output reg_req_t fifo_req_o,
  input  reg_rsp_t fifo_rsp_i,
  output reg_req_t pwr_req_o,
  input  reg_rsp_t pwr_rsp_i
);

  localparam logic [`ADDR_WIDTH-1:0] WIN_MASK = ~(`ADDR_WIDTH'(`PERIPH_SIZE - 1));

  periph_sel_t sel;
  logic [`ADDR_WIDTH-1:0] win_base;

  assign win_base = host_req_i.addr & WIN_MASK;

  always_comb begin
    if (win_base == `IFFIFO_BASE) begin
      sel = SEL_IFFIFO;
    end else if (win_base == `PWR_BASE) begin
      sel = SEL_PWR;
    end else begin
      sel = SEL_NONE;
    end
  end

  // Only the selected target sees valid
  always_comb begin
    fifo_req_o       = host_req_i;
    pwr_req_o        = host_req_i;
    fifo_req_o.valid = host_req_i.valid && (sel == SEL_IFFIFO);
    pwr_req_o.valid  = host_req_i.valid && (sel == SEL_PWR);
  end

  always_comb begin
    case (sel)
      SEL_IFFIFO: host_rsp_o = fifo_rsp_i;
      SEL_PWR:    host_rsp_o = pwr_rsp_i;
      default: begin
        host_rsp_o.ready = host_req_i.valid;
        host_rsp_o.error = host_req_i.valid;
        host_rsp_o.rdata = '0;
      end
    endcase
  end

  // Host must hold the request until it is accepted
  a_req_stable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    host_req_i.valid && !host_rsp_o.ready |=> $stable(host_req_i)
  );

endmodule

// File: switch_ack_delay.sv
/* Model of a power-switch cell: the acknowledge follows the request after a
   fixed number of cycles. One instance per mask type. */

`timescale 1ns/1ps

module switch_ack_delay #(
  parameter type ack_t   = logic,
  parameter int  LATENCY = 1
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  ack_t switch_n_i,
  output ack_t ack_n_o
);

  ack_t stage [LATENCY];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < LATENCY; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= switch_n_i;
      for (int i = 1; i < LATENCY; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign ack_n_o = stage[LATENCY-1];

endmodule

// File: tb_clk_gen.sv
/* Testbench clock and reset source. Drives a free-running clock and holds
   the synchronous active-low reset for a few cycles. */

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD     = 40,
  parameter int RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Release on a falling edge between two sampling edges
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// File: tb_ext_periph_subsys.sv
/* Testbench for the external-peripheral subsystem. Drives register accesses on
   the falling edge and checks every cycle against a model of the peripherals. */

`timescale 1ns/1ps

`include "ext_periph_macros.svh"

module tb_ext_periph_subsys import reg_bus_pkg::*, power_pkg::*; ();

  localparam int DEPTH = `IFFIFO_DEPTH;
  localparam int LAT   = `SWITCH_ACK_LATENCY;
  // Several times the length of the access sequence below
  localparam int TIMEOUT_CYCLES = 2000;

  localparam logic [`ADDR_WIDTH-1:0] FIFO_DATA   = `IFFIFO_BASE + 32'h0;
  localparam logic [`ADDR_WIDTH-1:0] FIFO_STATUS = `IFFIFO_BASE + 32'h4;
  localparam logic [`ADDR_WIDTH-1:0] FIFO_WM     = `IFFIFO_BASE + 32'h8;
  localparam logic [`ADDR_WIDTH-1:0] PWR_DOMAIN  = `PWR_BASE + 32'h0;
  localparam logic [`ADDR_WIDTH-1:0] PWR_BANK    = `PWR_BASE + 32'h4;
  localparam logic [`ADDR_WIDTH-1:0] PWR_ACK     = `PWR_BASE + 32'h8;
  localparam logic [`ADDR_WIDTH-1:0] PWR_IRQ     = `PWR_BASE + 32'hc;
  localparam logic [`ADDR_WIDTH-1:0] UNMAPPED    = 32'h0000_2000;

  logic         clk_i;
  logic         rst_n_i;
  reg_req_t     reg_req_i;
  reg_rsp_t     reg_rsp_o;
  domain_mask_t powergate_switch_n_o;
  bank_mask_t   bank_switch_n_o;
  logic         dma_slot_tx_o;
  logic         dma_slot_rx_o;
  intr_vec_t    intr_vector_o;

  // Reference model state
  logic [`DATA_WIDTH-1:0] fifo_q [$];
  logic [`DATA_WIDTH-1:0] wm_model = '0;
  domain_mask_t dom_model = '0;
  bank_mask_t   bank_model = '0;
  logic         pend_model = 1'b0;
  logic         irq_model = 1'b0;
  domain_mask_t dom_hist [LAT] = '{default: '0};
  bank_mask_t   bank_hist [LAT] = '{default: '0};

  domain_mask_t exp_dom_ack;
  bank_mask_t   exp_bank_ack;
  intr_vec_t    exp_intr;
  logic         settled;
  logic         wr_switch;
  int           issued = 0;
  int           checked = 0;
  int           cycle_cnt = 0;

  tb_clk_gen #(.PERIOD(40), .RST_CYCLES(3)) clk_gen_i (
    .clk_o   (clk_i),
    .rst_n_o (rst_n_i)
  );

  ext_periph_subsys uut (
    .clk_i                (clk_i),
    .rst_n_i              (rst_n_i),
    .reg_req_i            (reg_req_i),
    .reg_rsp_o            (reg_rsp_o),
    .powergate_switch_n_o (powergate_switch_n_o),
    .bank_switch_n_o      (bank_switch_n_o),
    .dma_slot_tx_o        (dma_slot_tx_o),
    .dma_slot_rx_o        (dma_slot_rx_o),
    .intr_vector_o        (intr_vector_o)
  );

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_rsp(input reg_rsp_t act, input reg_rsp_t exp);
    if (act !== exp) begin
      stop_on_error($sformatf("[ERROR] reg_rsp_o: got %h, expected %h", act, exp));
    end
  endtask

  task automatic check_intr(input intr_vec_t act, input intr_vec_t exp);
    if (act !== exp) begin
      stop_on_error($sformatf("[ERROR] intr_vector_o: got %h, expected %h", act, exp));
    end
  endtask

  task automatic check_domain(input domain_mask_t act, input domain_mask_t exp);
    if (act !== exp) begin
      stop_on_error($sformatf("[ERROR] powergate_switch_n_o: got %h, expected %h", act, exp));
    end
  endtask

  task automatic check_bank(input bank_mask_t act, input bank_mask_t exp);
    if (act !== exp) begin
      stop_on_error($sformatf("[ERROR] bank_switch_n_o: got %h, expected %h", act, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      stop_on_error($sformatf("[ERROR] %s: got %h, expected %h", name, act, exp));
    end
  endtask

  function automatic logic in_window(input logic [`ADDR_WIDTH-1:0] addr,
                                     input logic [`ADDR_WIDTH-1:0] base);
    return (addr & ~(`PERIPH_SIZE - 1)) == base;
  endfunction

  // Expected response from the register maps and the model state
  function automatic reg_rsp_t ref_rsp(input reg_req_t req, input domain_mask_t dom_ack,
                                       input bank_mask_t bank_ack);
    reg_rsp_t rsp;
    logic [`ADDR_WIDTH-1:0] ofs;
    rsp = '0;
    rsp.ready = 1'b1;
    ofs = req.addr & (`PERIPH_SIZE - 1);
    if (in_window(req.addr, `IFFIFO_BASE)) begin
      case (ofs)
        32'h0: begin
          if (req.write) begin
            rsp.error = (fifo_q.size() == DEPTH);
          end else if (fifo_q.size() == 0) begin
            rsp.error = 1'b1;
          end else begin
            rsp.rdata = fifo_q[0];
          end
        end
        32'h4: begin
          rsp.error = req.write;
          rsp.rdata = req.write ? '0 : 32'(fifo_q.size());
        end
        32'h8: rsp.rdata = req.write ? '0 : wm_model;
        default: rsp.error = 1'b1;
      endcase
    end else if (in_window(req.addr, `PWR_BASE)) begin
      case (ofs)
        32'h0: rsp.rdata = req.write ? '0 : 32'(dom_model);
        32'h4: rsp.rdata = req.write ? '0 : 32'(bank_model);
        32'h8: begin
          rsp.error = req.write;
          if (!req.write) begin
            rsp.rdata[0 +: `EXT_DOMAINS] = dom_ack;
            rsp.rdata[8 +: `NUM_BANKS]   = bank_ack;
          end
        end
        32'hc: rsp.rdata = req.write ? '0 : 32'(irq_model);
        default: rsp.error = 1'b1;
      endcase
    end else begin
      rsp.error = 1'b1;
    end
    return rsp;
  endfunction

  task automatic update_model(input reg_req_t req);
    logic [`ADDR_WIDTH-1:0] ofs;
    ofs = req.addr & (`PERIPH_SIZE - 1);
    if (in_window(req.addr, `IFFIFO_BASE)) begin
      if (ofs == 32'h0 && req.write && fifo_q.size() < DEPTH) begin
        fifo_q.push_back(req.wdata);
      end else if (ofs == 32'h0 && !req.write && fifo_q.size() > 0) begin
        void'(fifo_q.pop_front());
      end else if (ofs == 32'h8 && req.write) begin
        wm_model = req.wdata;
      end
    end else if (in_window(req.addr, `PWR_BASE) && req.write) begin
      if (ofs == 32'h0) begin
        dom_model = req.wdata[`EXT_DOMAINS-1:0];
        wr_switch = 1'b1;
      end else if (ofs == 32'h4) begin
        bank_model = req.wdata[`NUM_BANKS-1:0];
        wr_switch = 1'b1;
      end else if (ofs == 32'hc && req.wdata[0]) begin
        irq_model = 1'b0;
      end
    end
  endtask

  // Compares outputs every cycle and each completed access
  always @(posedge clk_i) begin
    exp_dom_ack  = dom_hist[LAT-1];
    exp_bank_ack = bank_hist[LAT-1];
    for (int i = LAT - 1; i > 0; i--) begin
      dom_hist[i]  = dom_hist[i-1];
      bank_hist[i] = bank_hist[i-1];
    end
    dom_hist[0]  = dom_model;
    bank_hist[0] = bank_model;
    if (rst_n_i) begin
      exp_intr.iffifo_irq = (wm_model != 0) && (fifo_q.size() >= wm_model);
      exp_intr.pwr_irq    = irq_model;
      check_intr(intr_vector_o, exp_intr);
      check_bit("dma_slot_tx_o", dma_slot_tx_o, fifo_q.size() < DEPTH);
      check_bit("dma_slot_rx_o", dma_slot_rx_o, fifo_q.size() > 0);
      check_domain(powergate_switch_n_o, dom_model);
      check_bank(bank_switch_n_o, bank_model);
      settled   = pend_model && (exp_dom_ack == dom_model) && (exp_bank_ack == bank_model);
      wr_switch = 1'b0;
      if (reg_req_i.valid) begin
        check_rsp(reg_rsp_o, ref_rsp(reg_req_i, exp_dom_ack, exp_bank_ack));
        update_model(reg_req_i);
        checked++;
      end
      if (settled) begin
        pend_model = 1'b0;
        irq_model  = 1'b1;
      end
      if (wr_switch) begin
        pend_model = 1'b1;
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      stop_on_error("Timeout: the test sequence did not finish within the cycle limit");
    end
  end

  task automatic bus_access(input logic write, input logic [`ADDR_WIDTH-1:0] addr,
                            input logic [`DATA_WIDTH-1:0] wdata);
    @(negedge clk_i);
    reg_req_i.valid = 1'b1;
    reg_req_i.write = write;
    reg_req_i.addr  = addr;
    reg_req_i.wdata = wdata;
    @(posedge clk_i);
    while (!reg_rsp_o.ready) begin
      @(posedge clk_i);
    end
    issued++;
    @(negedge clk_i);
    reg_req_i = '0;
  endtask

  task automatic bus_write(input logic [`ADDR_WIDTH-1:0] addr,
                           input logic [`DATA_WIDTH-1:0] wdata);
    bus_access(1'b1, addr, wdata);
  endtask

  task automatic bus_read(input logic [`ADDR_WIDTH-1:0] addr);
    bus_access(1'b0, addr, '0);
  endtask

  initial begin : stimulus
    domain_mask_t dom;
    bank_mask_t   bank;
    reg_req_i = '0;
    void'($urandom(32'h223f));
    @(posedge rst_n_i);

    bus_read(FIFO_STATUS);
    bus_read(PWR_ACK);
    bus_read(PWR_IRQ);

    // Partial fill, then full, one push too many and a pop past empty
    repeat (5) bus_write(FIFO_DATA, $urandom);
    bus_read(FIFO_STATUS);
    repeat (5) bus_read(FIFO_DATA);
    repeat (DEPTH + 1) bus_write(FIFO_DATA, $urandom);
    bus_read(FIFO_STATUS);
    repeat (DEPTH + 1) bus_read(FIFO_DATA);

    bus_read(UNMAPPED);
    bus_write(UNMAPPED, $urandom);
    bus_write(FIFO_STATUS, $urandom);
    bus_write(PWR_ACK, $urandom);

    // Watermark at 3
    bus_write(FIFO_WM, 32'd3);
    bus_read(FIFO_WM);
    repeat (2) bus_write(FIFO_DATA, $urandom);
    bus_read(FIFO_STATUS);
    bus_write(FIFO_DATA, $urandom);
    bus_read(FIFO_STATUS);
    bus_read(FIFO_DATA);
    bus_write(FIFO_WM, 32'd0);
    repeat (2) bus_read(FIFO_DATA);

    // Nonzero masks so the acks visibly change
    dom  = domain_mask_t'($urandom_range(1, (1 << `EXT_DOMAINS) - 1));
    bank = bank_mask_t'($urandom_range(1, (1 << `NUM_BANKS) - 1));
    bus_write(PWR_DOMAIN, 32'(dom));
    bus_write(PWR_BANK, 32'(bank));
    bus_read(PWR_ACK);
    bus_read(PWR_DOMAIN);
    bus_read(PWR_BANK);
    repeat (LAT + 1) @(negedge clk_i);
    bus_read(PWR_ACK);
    bus_read(PWR_IRQ);
    bus_write(PWR_IRQ, 32'd1);
    bus_read(PWR_IRQ);
    repeat (4) @(negedge clk_i);

    if (checked != issued) begin
      stop_on_error($sformatf("Only %0d of %0d accesses were checked", checked, issued));
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule
